// ==== logic/race_view_pkg.sv ====
`default_nettype none

package race_view_pkg;

    typedef logic [9:0]  pixel_coord_t;   // screen counter
    typedef logic [9:0]  world_coord_t;   // map coordinate
    typedef logic [18:0] map_addr_t;      // row-major map address
    typedef logic [1:0]  color_index_t;   // map memory color code
    typedef logic [11:0] rgb_t;           // 4:4:4

    // ============================================================
    // 640x480 @ 60 Hz timing
    // ============================================================
    localparam pixel_coord_t H_ACTIVE = 10'd640;
    localparam pixel_coord_t H_FRONT  = 10'd16;
    localparam pixel_coord_t H_SYNC   = 10'd96;
    localparam pixel_coord_t H_BACK   = 10'd48;
    localparam pixel_coord_t V_ACTIVE = 10'd480;
    localparam pixel_coord_t V_FRONT  = 10'd10;
    localparam pixel_coord_t V_SYNC   = 10'd2;
    localparam pixel_coord_t V_BACK   = 10'd33;

    // ============================================================
    // screen layout
    // ============================================================
    localparam pixel_coord_t VIEW_WIDTH    = 10'd320;  // one half-screen
    localparam pixel_coord_t HUD_TOP       = 10'd360;
    localparam pixel_coord_t MINI_LEFT     = 10'd240;
    localparam pixel_coord_t MINI_RIGHT    = 10'd400;
    localparam world_coord_t VIEW_OFFSET_X = 10'd40;   // viewer sits 40 units in
    localparam world_coord_t VIEW_OFFSET_Y = 10'd60;
    localparam world_coord_t DOT_RADIUS    = 10'd6;

    // map color codes 0..3
    localparam rgb_t map_palette [0:3] = '{12'h6B4, 12'h888, 12'hFFF, 12'h2A2};

    localparam rgb_t SEPARATOR_COLOR = 12'hFFF;
    localparam rgb_t OUT_BOUND_COLOR = 12'h6B4;
    localparam rgb_t HUD_COLOR       = 12'h444;
    localparam rgb_t P1_DOT_COLOR    = 12'hF00;  // red
    localparam rgb_t P2_DOT_COLOR    = 12'h00F;  // blue

    typedef enum logic {WAIT_REQ, HOLD_ACK} pos_port_state_t;

endpackage

`default_nettype wire

// ==== logic/vga_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

module vga_timing import race_view_pkg::*; (
    input  wire          clk_25MHz,
    input  wire          rst,
    output pixel_coord_t h_cnt,
    output pixel_coord_t v_cnt,
    output logic         hsync_raw,
    output logic         vsync_raw
);

    // frame totals, 800 x 525
    localparam pixel_coord_t H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam pixel_coord_t V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // sync pulse starts after active + front porch
    localparam pixel_coord_t H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam pixel_coord_t H_SYNC_END   = H_ACTIVE + H_FRONT + H_SYNC;
    localparam pixel_coord_t V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam pixel_coord_t V_SYNC_END   = V_ACTIVE + V_FRONT + V_SYNC;

    logic h_last;
    logic v_last;

    assign h_last = (h_cnt == H_TOTAL - 10'd1);
    assign v_last = (v_cnt == V_TOTAL - 10'd1);

    // ============================================================
    // pixel and line counters
    // ============================================================
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            if (v_last) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 10'd1;  // next line
            end
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    // active-low pulses, decoded straight from the counters
    assign hsync_raw = !((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END));
    assign vsync_raw = !((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END));

endmodule

`default_nettype wire

// ==== logic/player_pos_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module player_pos_port import race_view_pkg::*; #(
    parameter world_coord_t P1_START_X = 10'd15,
    parameter world_coord_t P1_START_Y = 10'd125,
    parameter world_coord_t P2_START_X = 10'd25,
    parameter world_coord_t P2_START_Y = 10'd125
) (
    input  wire          clk_25MHz,
    input  wire          rst,
    input  wire          pos_req,
    input  wire          pos_player,  // 0 = p1, 1 = p2
    input  world_coord_t pos_x,
    input  world_coord_t pos_y,
    output logic         pos_ack,
    output world_coord_t p1_x,
    output world_coord_t p1_y,
    output world_coord_t p2_x,
    output world_coord_t p2_y
);

    pos_port_state_t state;

    // four-phase req/ack, data captured on the way into HOLD_ACK
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            state <= WAIT_REQ;
            p1_x  <= P1_START_X;
            p1_y  <= P1_START_Y;
            p2_x  <= P2_START_X;
            p2_y  <= P2_START_Y;
        end else begin
            case (state)
                WAIT_REQ: if (pos_req) begin
                    state <= HOLD_ACK;
                    if (pos_player) begin
                        p2_x <= pos_x;
                        p2_y <= pos_y;
                    end else begin
                        p1_x <= pos_x;
                        p1_y <= pos_y;
                    end
                end
                HOLD_ACK: if (!pos_req) state <= WAIT_REQ;  // req dropped, release ack
                default:  state <= WAIT_REQ;
            endcase
        end
    end

    assign pos_ack = (state == HOLD_ACK);

endmodule

`default_nettype wire

// ==== logic/view_address_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module view_address_gen import race_view_pkg::*; #(
    parameter world_coord_t MAP_WIDTH  = 10'd640,
    parameter world_coord_t MAP_HEIGHT = 10'd480
) (
    input  wire          clk_25MHz,
    input  wire          rst,
    input  pixel_coord_t h_cnt,
    input  pixel_coord_t v_cnt,
    input  wire          hsync_raw,
    input  wire          vsync_raw,
    input  world_coord_t p1_x,
    input  world_coord_t p1_y,
    input  world_coord_t p2_x,
    input  world_coord_t p2_y,
    output map_addr_t    map_addr,
    output map_addr_t    mini_addr,
    output logic         visible,
    output logic         hud_sep,
    output logic         in_hud,
    output logic         in_mini,
    output logic         view_sep,
    output logic         out_of_map,
    output logic         p1_dot,
    output logic         p2_dot,
    output logic         hsync_d,
    output logic         vsync_d
);

    pixel_coord_t rel_x;
    world_coord_t view_x, view_y;
    world_coord_t map_x, map_y;
    world_coord_t scan_x, scan_y;
    logic         outside, mini_area;

    function automatic logic near_dot(world_coord_t a, world_coord_t b);
        world_coord_t diff;
        diff = (a >= b) ? a - b : b - a;
        return diff <= DOT_RADIUS;
    endfunction

    // ============================================================
    // viewer select and world position, 4x zoom
    // ============================================================
    always_comb begin
        if (h_cnt < VIEW_WIDTH) begin
            rel_x  = h_cnt;  // left half follows p1
            view_x = p1_x;
            view_y = p1_y;
        end else begin
            rel_x  = h_cnt - VIEW_WIDTH;
            view_x = p2_x;
            view_y = p2_y;
        end
    end

    assign map_x   = world_coord_t'(rel_x >> 2) + view_x - VIEW_OFFSET_X;  // wraps at 10 bits
    assign map_y   = world_coord_t'(v_cnt >> 2) + view_y - VIEW_OFFSET_Y;
    assign outside = (map_x >= MAP_WIDTH) || (map_y >= MAP_HEIGHT);

    // minimap shows the whole map at 1/4 scale
    assign mini_area = (h_cnt >= MINI_LEFT) && (h_cnt < MINI_RIGHT) && (v_cnt >= HUD_TOP);
    assign scan_x    = world_coord_t'(h_cnt - MINI_LEFT) << 2;
    assign scan_y    = world_coord_t'(v_cnt - HUD_TOP) << 2;

    always_ff @(posedge clk_25MHz) begin
        map_addr   <= outside ? '0 :
                      map_addr_t'(map_y) * map_addr_t'(MAP_WIDTH) + map_addr_t'(map_x);
        mini_addr  <= !mini_area ? '0 :
                      map_addr_t'(scan_y) * map_addr_t'(MAP_WIDTH) + map_addr_t'(scan_x);
        out_of_map <= outside;
        in_mini    <= mini_area;
        hud_sep    <= (v_cnt == HUD_TOP - 10'd1) || (v_cnt == HUD_TOP);
        in_hud     <= (v_cnt >= HUD_TOP);
        view_sep   <= (h_cnt == VIEW_WIDTH - 10'd1) || (h_cnt == VIEW_WIDTH);
        p1_dot     <= near_dot(scan_x, p1_x) && near_dot(scan_y, p1_y);
        p2_dot     <= near_dot(scan_x, p2_x) && near_dot(scan_y, p2_y);
    end

    // blanking and sync ride along with the addresses
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            visible <= 1'b0;
            hsync_d <= 1'b1;
            vsync_d <= 1'b1;
        end else begin
            visible <= (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
            hsync_d <= hsync_raw;
            vsync_d <= vsync_raw;
        end
    end

endmodule

`default_nettype wire

// ==== logic/pixel_compositor.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixel_compositor import race_view_pkg::*; (
    input  wire          clk_25MHz,
    input  wire          rst,
    input  wire          visible,
    input  wire          hud_sep,
    input  wire          in_hud,
    input  wire          in_mini,
    input  wire          view_sep,
    input  wire          out_of_map,
    input  wire          p1_dot,
    input  wire          p2_dot,
    input  wire          hsync_d,
    input  wire          vsync_d,
    input  color_index_t map_index,
    input  color_index_t mini_index,
    output rgb_t         rgb,
    output logic         hsync,
    output logic         vsync
);

    logic visible_q, hsync_q, vsync_q;
    logic hud_sep_q, in_hud_q, in_mini_q, view_sep_q;
    logic out_of_map_q, p1_dot_q, p2_dot_q;
    rgb_t color;

    // ============================================================
    // align flags with the memory read latency
    // ============================================================
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            visible_q <= 1'b0;
            hsync_q   <= 1'b1;
            vsync_q   <= 1'b1;
        end else begin
            visible_q <= visible;
            hsync_q   <= hsync_d;
            vsync_q   <= vsync_d;
        end
    end

    always_ff @(posedge clk_25MHz) begin
        hud_sep_q    <= hud_sep;
        in_hud_q     <= in_hud;
        in_mini_q    <= in_mini;
        view_sep_q   <= view_sep;
        out_of_map_q <= out_of_map;
        p1_dot_q     <= p1_dot;
        p2_dot_q     <= p2_dot;
    end

    // overlay priority, top entry wins
    always_comb begin
        if (!visible_q) begin
            color = '0;  // blanking
        end else if (hud_sep_q) begin
            color = SEPARATOR_COLOR;
        end else if (in_hud_q) begin
            if (in_mini_q) begin
                if (p1_dot_q)      color = P1_DOT_COLOR;  // red on top of blue
                else if (p2_dot_q) color = P2_DOT_COLOR;
                else               color = map_palette[mini_index];
            end else begin
                color = HUD_COLOR;
            end
        end else if (view_sep_q) begin
            color = SEPARATOR_COLOR;
        end else if (out_of_map_q) begin
            color = OUT_BOUND_COLOR;
        end else begin
            color = map_palette[map_index];
        end
    end

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            rgb   <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            rgb   <= color;
            hsync <= hsync_q;
            vsync <= vsync_q;
        end
    end

endmodule

`default_nettype wire

// ==== logic/race_view_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module race_view_top import race_view_pkg::*; #(
    parameter world_coord_t MAP_WIDTH  = 10'd640,
    parameter world_coord_t MAP_HEIGHT = 10'd480,
    parameter world_coord_t P1_START_X = 10'd15,
    parameter world_coord_t P1_START_Y = 10'd125,
    parameter world_coord_t P2_START_X = 10'd25,
    parameter world_coord_t P2_START_Y = 10'd125
) (
    input  wire          clk_25MHz,
    input  wire          rst,
    input  wire          pos_req,
    input  wire          pos_player,
    input  world_coord_t pos_x,
    input  world_coord_t pos_y,
    output logic         pos_ack,
    output map_addr_t    map_addr,    // to external map RAM, port a
    output map_addr_t    mini_addr,   // port b
    input  color_index_t map_index,
    input  color_index_t mini_index,
    output rgb_t         rgb,
    output logic         hsync,
    output logic         vsync
);

    pixel_coord_t h_cnt, v_cnt;
    logic         hsync_raw, vsync_raw, hsync_d, vsync_d;
    world_coord_t p1_x, p1_y, p2_x, p2_y;
    logic         visible, hud_sep, in_hud, in_mini;
    logic         view_sep, out_of_map, p1_dot, p2_dot;

    vga_timing vga_timing_i (.*);

    player_pos_port #(
        .P1_START_X(P1_START_X), .P1_START_Y(P1_START_Y),
        .P2_START_X(P2_START_X), .P2_START_Y(P2_START_Y)
    ) player_pos_port_i (.*);

    view_address_gen #(
        .MAP_WIDTH(MAP_WIDTH), .MAP_HEIGHT(MAP_HEIGHT)
    ) view_address_gen_i (.*);

    pixel_compositor pixel_compositor_i (.*);

endmodule

`default_nettype wire

// ==== verification/race_view_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module race_view_sva (
    input wire clk_25MHz,
    input wire rst,
    input wire pos_req,
    input wire pos_ack,
    input wire hsync
);

    logic [7:0] low_len;  // hsync low cycles so far

    always_ff @(posedge clk_25MHz) begin
        if (rst || hsync) begin
            low_len <= '0;
        end else begin
            low_len <= low_len + 8'd1;
        end
    end

    // ack only answers a request
    ack_needs_req: assert property (@(posedge clk_25MHz) disable iff (rst)
        $rose(pos_ack) |-> $past(pos_req))
        else $error("pos_ack rose without pos_req");

    ack_held: assert property (@(posedge clk_25MHz) disable iff (rst)
        pos_ack && pos_req |=> pos_ack)
        else $error("pos_ack dropped while pos_req was high");

    hsync_width: assert property (@(posedge clk_25MHz) disable iff (rst)
        $rose(hsync) |-> low_len == 8'd96)
        else $error("hsync low pulse lasted %0d cycles instead of 96", low_len);

endmodule

bind race_view_top race_view_sva race_view_sva_i (.*);

`default_nettype wire

// ==== verification/race_view_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module race_view_tb;

    localparam int MAP_W = 640;
    localparam int MAP_H = 480;

    logic        clk_25MHz = 1'b0;
    logic        rst;
    logic        pos_req, pos_player, pos_ack;
    logic [9:0]  pos_x, pos_y;
    logic [18:0] map_addr, mini_addr;
    logic [18:0] map_addr_q, mini_addr_q;      // addresses seen by the memory model
    logic [18:0] exp_map_addr, exp_mini_addr;  // due from the DUT one cycle later
    logic [1:0]  map_index, mini_index;
    logic [11:0] rgb;
    logic        hsync, vsync;

    int          p1x = 15, p1y = 125, p2x = 25, p2y = 125;  // model positions
    int          mh, mv;                                    // model pixel counters
    int          cycle, checks, errors;
    logic        ack_q;
    logic        timed_out;
    logic [33:0] expect_q [$];  // {v, h, hsync, vsync, rgb}

    race_view_top race_view_top_i (.*);

    always #20 clk_25MHz = ~clk_25MHz;

    // ============================================================
    // reference model
    // ============================================================
    function automatic logic [1:0] mem_index(input logic [18:0] addr);
        return addr[1:0] ^ addr[8:7];
    endfunction

    function automatic logic [11:0] palette_color(input logic [1:0] idx);
        case (idx)
            2'd0:    return 12'h6B4;
            2'd1:    return 12'h888;
            2'd2:    return 12'hFFF;
            default: return 12'h2A2;
        endcase
    endfunction

    function automatic logic near(input int a, input int b);
        return (a - b <= 6) && (b - a <= 6);
    endfunction

    // world pixel under the screen pixel
    function automatic void world_pixel(input int h, input int v,
                                        output int mx, output int my);
        int rx, vx, vy;
        rx = (h < 320) ? h : h - 320;
        vx = (h < 320) ? p1x : p2x;
        vy = (h < 320) ? p1y : p2y;
        mx = (rx / 4 + vx - 40) & 1023;  // 10-bit world wrap
        my = (v / 4 + vy - 60) & 1023;
    endfunction

    function automatic logic [18:0] expected_map_addr(input int h, input int v);
        int mx, my;
        world_pixel(h, v, mx, my);
        if (mx >= MAP_W || my >= MAP_H) return '0;
        return 19'(my * MAP_W + mx);
    endfunction

    function automatic logic [18:0] expected_mini_addr(input int h, input int v);
        if (h < 240 || h >= 400 || v < 360) return '0;  // outside the minimap
        return 19'((v - 360) * 4 * MAP_W + (h - 240) * 4);
    endfunction

    function automatic logic [11:0] expected_rgb(input int h, input int v);
        int mx, my, sx, sy;
        if (h >= 640 || v >= 480) return 12'h000;  // blanking
        if (v == 359 || v == 360) return 12'hFFF;
        if (v >= 360) begin
            if (h < 240 || h >= 400) return 12'h444;
            sx = (h - 240) * 4;  // minimap at quarter scale
            sy = (v - 360) * 4;
            if (near(sx, p1x) && near(sy, p1y)) return 12'hF00;
            if (near(sx, p2x) && near(sy, p2y)) return 12'h00F;
            return palette_color(mem_index(expected_mini_addr(h, v)));
        end
        if (h == 319 || h == 320) return 12'hFFF;
        world_pixel(h, v, mx, my);
        if (mx >= MAP_W || my >= MAP_H) return 12'h6B4;
        return palette_color(mem_index(expected_map_addr(h, v)));
    endfunction

    task automatic check_idle();
        checks++;
        if (rgb !== 12'h000 || hsync !== 1'b1 || vsync !== 1'b1 || pos_ack !== 1'b0) begin
            errors++;
            $display("error: rgb=%h hsync=%h vsync=%h pos_ack=%h, expected 000 1 1 0",
                     rgb, hsync, vsync, pos_ack);
        end
    endtask

    task automatic check_addr(input logic [18:0] exp_map, input logic [18:0] exp_mini);
        checks++;
        if (map_addr !== exp_map) begin
            errors++;
            $display("error: map_addr=%h expected %h", map_addr, exp_map);
        end
        if (mini_addr !== exp_mini) begin
            errors++;
            $display("error: mini_addr=%h expected %h", mini_addr, exp_mini);
        end
    endtask

    task automatic check_pixel(input logic [33:0] e);
        checks++;
        if (rgb !== e[11:0]) begin
            errors++;
            $display("error: rgb=%h expected %h at (%0d,%0d)", rgb, e[11:0], e[23:14], e[33:24]);
        end
        if (hsync !== e[13]) begin
            errors++;
            $display("error: hsync=%h expected %h at (%0d,%0d)", hsync, e[13], e[23:14], e[33:24]);
        end
        if (vsync !== e[12]) begin
            errors++;
            $display("error: vsync=%h expected %h at (%0d,%0d)", vsync, e[12], e[23:14], e[33:24]);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // one clock step at the falling edge
    task automatic step();
        logic hs, vs;
        @(negedge clk_25MHz);
        cycle++;
        if (cycle == 5) rst = 1'b0;
        map_index   = mem_index(map_addr_q);  // one cycle read latency
        mini_index  = mem_index(mini_addr_q);
        map_addr_q  = map_addr;
        mini_addr_q = mini_addr;
        if (pos_ack === 1'b1 && ack_q !== 1'b1) begin  // new position from this cycle on
            if (pos_player) begin
                p2x = int'(pos_x);
                p2y = int'(pos_y);
            end else begin
                p1x = int'(pos_x);
                p1y = int'(pos_y);
            end
        end
        ack_q = pos_ack;
        if (cycle >= 5) begin
            if (cycle > 5) begin
                check_addr(exp_map_addr, exp_mini_addr);
            end
            exp_map_addr  = expected_map_addr(mh, mv);
            exp_mini_addr = expected_mini_addr(mh, mv);
            hs = !(mh >= 656 && mh < 752);
            vs = !(mv >= 490 && mv < 492);
            expect_q.push_back({10'(mv), 10'(mh), hs, vs, expected_rgb(mh, mv)});
            mh++;
            if (mh == 800) begin
                mh = 0;
                mv = (mv == 524) ? 0 : mv + 1;
            end
        end
        if (expect_q.size() == 4) begin
            check_pixel(expect_q.pop_front());  // three cycles through the pipeline
        end else begin
            check_idle();
        end
    endtask

    // ============================================================
    // stimulus
    // ============================================================
    task automatic wait_for_line(input int line);
        int n;
        n = 0;
        while (!(mh == 0 && mv == line) && n < 800 * 526) begin
            step();
            n++;
        end
        if (!(mh == 0 && mv == line)) begin
            $display("timeout: line %0d was never reached", line);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic send_position();
        int n;
        pos_player = 1'($urandom_range(1, 0));
        pos_x      = 10'($urandom_range(600, 8));
        pos_y      = 10'($urandom_range(600, 8));
        pos_req    = 1'b1;
        n = 0;
        while (pos_ack !== 1'b1 && n < 16) begin
            step();
            n++;
        end
        if (pos_ack !== 1'b1) begin
            $display("timeout: pos_ack never rose after pos_req");
            errors++;
            timed_out = 1'b1;
            return;
        end
        repeat ($urandom_range(3, 0)) begin  // slow source
            step();
            if (pos_ack !== 1'b1) begin
                errors++;
                $display("error: pos_ack=%h while pos_req held, expected 1", pos_ack);
            end
        end
        pos_req = 1'b0;
        n = 0;
        while (pos_ack !== 1'b0 && n < 16) begin
            step();
            n++;
        end
        if (pos_ack !== 1'b0) begin
            $display("timeout: pos_ack did not fall after pos_req dropped");
            errors++;
            timed_out = 1'b1;
            return;
        end
        repeat ($urandom_range(4, 0)) step();
    endtask

    initial begin
        void'($urandom(88));
        rst         = 1'b1;
        pos_req     = 1'b0;
        pos_player  = 1'b0;
        pos_x       = '0;
        pos_y       = '0;
        map_index   = '0;
        mini_index  = '0;
        map_addr_q  = '0;
        mini_addr_q = '0;
        ack_q       = 1'b0;
        timed_out   = 1'b0;
        repeat (5) step();  // rst drops on the 5th falling edge
        for (int frame = 0; frame < 3 && !timed_out; frame++) begin
            wait_for_line(480);  // start of vertical blanking
            for (int k = 0; k < 2 && !timed_out; k++) begin
                send_position();
            end
        end
        if (!timed_out) begin
            wait_for_line(480);
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== all.f ====
logic/race_view_pkg.sv
logic/vga_timing.sv
logic/player_pos_port.sv
logic/view_address_gen.sv
logic/pixel_compositor.sv
logic/race_view_top.sv
verification/race_view_sva.sv
verification/race_view_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module race_view_tb -f all.f

out=$(./obj_dir/Vrace_view_tb)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1
